//--- rtl/conv_pkg.sv
package conv_pkg;

    typedef logic signed [7:0]  pixel_t;    // One input pixel
    typedef logic signed [7:0]  weight_t;   // One kernel weight and one memory word
    typedef logic signed [19:0] sum_t;      // Wide enough for nine 16 bit products
    typedef logic [3:0]         kw_t;       // Odd kernel width, 3 and up
    typedef logic [9:0]         col_t;      // Column count or column index
    typedef logic [3:0]         waddr_t;    // Weight memory address

    typedef enum logic [1:0] {
        FETCH_IDLE,                         // Weights valid or never loaded
        FETCH_ISSUE,                        // Read requests going out
        FETCH_DRAIN                         // Waiting for the last read word
    } fetch_state_t;

    typedef enum logic {
        OWNER_HOST,                         // Host write port held the last grant
        OWNER_FETCH                         // Weight fetcher held the last grant
    } arb_owner_t;

endpackage

//--- rtl/mem_bus_if.sv
interface mem_bus_if
    import conv_pkg::*;
();

    logic    req;       // Held with we, addr and wdata until gnt
    logic    gnt;       // One cycle, the access happens in it
    logic    we;        // Write when high, read when low
    waddr_t  addr;
    weight_t wdata;
    weight_t rdata;     // Valid together with rvalid
    logic    rvalid;    // Pulses one cycle after a granted read

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport store (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

//--- rtl/host_write_port.sv
module host_write_port
    import conv_pkg::*;
(
    input  logic         aclk,
    input  logic         rst_n,
    input  logic         wr_en,
    input  waddr_t       wr_addr,
    input  weight_t      wr_data,
    output logic         wr_busy,
    mem_bus_if.requester bus
);

    logic    accept;    // Strobe taken into the buffer
    waddr_t  addr_q;    // Buffered write address
    weight_t data_q;    // Buffered write data

    assign accept = wr_en && !wr_busy;  // A strobe while busy is lost

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
        end else if (accept) begin
            wr_busy <= 1'b1;                // Buffer full from the next cycle
        end else if (bus.gnt) begin
            wr_busy <= 1'b0;                // Write done in the grant cycle
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= wr_addr;
            data_q <= wr_data;
        end
    end

    assign bus.req   = wr_busy;             // Request stays up until granted
    assign bus.we    = 1'b1;                // This port only ever writes
    assign bus.addr  = addr_q;
    assign bus.wdata = data_q;

endmodule

//--- rtl/weight_fetch.sv
module weight_fetch
    import conv_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7
) (
    input  logic                         aclk,
    input  logic                         rst_n,
    input  logic                         start,
    input  kw_t                          kernel_w,
    output logic                         ready,
    output weight_t [KERNEL_W_MAX-1:0]   weights,
    mem_bus_if.requester                 bus
);

    fetch_state_t state;
    kw_t          kw_q;         // Kernel width of the fetch in flight
    waddr_t       rd_addr;      // Next address to request
    waddr_t       rd_cnt;       // Words returned so far
    waddr_t       last_addr;    // Highest address of this kernel
    logic         take;         // Start accepted

    assign last_addr = waddr_t'(kw_q - kw_t'(1));
    assign take      = start && state == FETCH_IDLE;   // Ignored while a fetch runs

    assign bus.req   = state == FETCH_ISSUE;
    assign bus.we    = 1'b0;
    assign bus.addr  = rd_addr;
    assign bus.wdata = '0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= FETCH_IDLE;
            ready   <= 1'b0;                // Low until a first kernel is in
            kw_q    <= '0;
            rd_addr <= '0;
            rd_cnt  <= '0;
        end else begin
            case (state)
                FETCH_IDLE: if (take) begin
                    kw_q    <= kernel_w;
                    rd_addr <= '0;
                    rd_cnt  <= '0;
                    ready   <= 1'b0;        // Falls the cycle after start
                    state   <= FETCH_ISSUE;
                end
                FETCH_ISSUE: if (bus.gnt) begin
                    rd_addr <= rd_addr + waddr_t'(1);   // One address per granted cycle
                    if (rd_addr == last_addr) state <= FETCH_DRAIN;
                end
                FETCH_DRAIN: if (bus.rvalid && rd_cnt == last_addr) begin
                    ready <= 1'b1;          // Rises after the final word lands
                    state <= FETCH_IDLE;
                end
                default: state <= FETCH_IDLE;
            endcase
            if (bus.rvalid) rd_cnt <= rd_cnt + waddr_t'(1);
        end
    end

    // Word at address a feeds datapath a, which sees the oldest pixel of the window
    always_ff @(posedge aclk) begin
        if (take) begin
            weights <= '0;                  // Datapaths past kw multiply by zero
        end else if (bus.rvalid) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                if (rd_cnt == waddr_t'(i)) weights[i] <= bus.rdata;
            end
        end
    end

endmodule

//--- rtl/weight_store.sv
module weight_store
    import conv_pkg::*;
(
    input  logic     aclk,
    input  logic     rst_n,
    mem_bus_if.store host_bus,
    mem_bus_if.store fetch_bus
);

    weight_t    mem [0:15];     // Single port weight memory
    arb_owner_t last_owner;     // Who held the previous grant
    logic       host_win;
    logic       fetch_win;
    logic       mem_we;
    waddr_t     mem_addr;
    weight_t    mem_wdata;
    weight_t    rdata_q;        // Read word, shared by both ports
    logic       host_rd_q;      // Host read was granted last cycle
    logic       fetch_rd_q;     // Fetch read was granted last cycle

    // On a tie the port that did not own the last grant goes first
    assign host_win  = host_bus.req && (!fetch_bus.req || last_owner == OWNER_FETCH);
    assign fetch_win = fetch_bus.req && !host_win;   // A lone request wins at once

    assign host_bus.gnt  = host_win;
    assign fetch_bus.gnt = fetch_win;

    assign mem_addr  = host_win ? host_bus.addr : fetch_bus.addr;
    assign mem_wdata = host_win ? host_bus.wdata : fetch_bus.wdata;
    assign mem_we    = (host_win && host_bus.we) || (fetch_win && fetch_bus.we);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            last_owner <= OWNER_FETCH;      // Host wins the first tie
        end else if (host_win) begin
            last_owner <= OWNER_HOST;
        end else if (fetch_win) begin
            last_owner <= OWNER_FETCH;
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_we) mem[mem_addr] <= mem_wdata;
        rdata_q <= mem[mem_addr];           // Read first, a write shows next access
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            host_rd_q  <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            host_rd_q  <= host_win && !host_bus.we;
            fetch_rd_q <= fetch_win && !fetch_bus.we;
        end
    end

    assign host_bus.rdata   = rdata_q;
    assign fetch_bus.rdata  = rdata_q;
    assign host_bus.rvalid  = host_rd_q;    // Only the granted reader sees a pulse
    assign fetch_bus.rvalid = fetch_rd_q;

endmodule

//--- rtl/pad_filter.sv
module pad_filter
    import conv_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7
) (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    start,
    input  kw_t                     kernel_w,
    input  logic                    col_valid,
    input  logic                    col_is_tail,
    output logic [KERNEL_W_MAX-1:1] mask_partial,
    output logic [KERNEL_W_MAX-1:0] mask_full
);

    localparam int KW2_MAX = KERNEL_W_MAX / 2;    // Largest half width

    kw_t              kw2_q;        // Half width of the running kernel, 1 and up
    logic [KW2_MAX:1] col_end;      // Bit k is set on column cols-1-kw2+k
    logic [KW2_MAX:1] col_start;    // Bit k is set on column k-1 of a row

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            kw2_q <= kw_t'(1);
        end else if (start) begin
            kw2_q <= kernel_w >> 1;         // Selects the lookup column below
        end
    end

    // Tail flag walks through the end bits and then into the start bits
    always_ff @(posedge aclk) begin
        if (!rst_n || start) begin
            col_end   <= '0;
            col_start <= '1;                // First row starts masked
        end else if (col_valid) begin
            col_end[1]   <= col_is_tail;
            col_start[1] <= col_end[kw2_q]; // The last column opens the next row
            for (int k = 2; k <= KW2_MAX; k++) begin
                col_end[k]   <= col_end[k-1];
                col_start[k] <= col_start[k-1];
            end
        end
    end

    // Full sums, one lookup entry per odd kernel so widths can change per row
    for (genvar i = 0; i < KERNEL_W_MAX; i++) begin : g_full
        logic [KW2_MAX:1] allow;

        for (genvar r = 1; r <= KW2_MAX; r++) begin : g_kw
            logic full_dp;      // Datapath kw-1 ends every window
            logic in_start;     // First r columns have no output yet
            logic at_last;      // Datapaths r to 2r finish the padded tail

            assign full_dp  = i == 2 * r;
            assign in_start = |col_start[r:1];
            assign at_last  = col_end[r] && i >= r && i <= 2 * r;
            assign allow[r] = (full_dp && !in_start) || at_last;
        end

        assign mask_full[i] = allow[kw2_q];
    end

    // Partial sums are cut where they would carry pixels across a row boundary
    for (genvar i = 1; i < KERNEL_W_MAX; i++) begin : g_part
        logic [KW2_MAX:1] stop;

        for (genvar r = 1; r <= KW2_MAX; r++) begin : g_kw
            if (i > r) begin : g_high
                assign stop[r] = i > 2 * r;             // Past the kernel, not used
            end else begin : g_low
                assign stop[r] = |col_end[r:i];         // Triangle of blocked carries
            end
        end

        assign mask_partial[i] = !stop[kw2_q];
    end

endmodule

//--- rtl/conv_row_engine.sv
module conv_row_engine
    import conv_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7
) (
    input  logic                         aclk,
    input  logic                         rst_n,
    input  logic                         start,
    input  kw_t                          kernel_w,
    input  col_t                         row_cols,
    input  logic                         ready,
    input  logic                         pixel_valid,
    input  pixel_t                       pixel,
    input  weight_t [KERNEL_W_MAX-1:0]   weights,
    output logic                         out_valid,
    output logic [KERNEL_W_MAX-1:0]      out_keep,
    output sum_t [KERNEL_W_MAX-1:0]      out_sums
);

    kw_t                     kw_q;          // Kernel width for the tail position
    col_t                    cols_q;        // Row width
    col_t                    col_q;         // Column of the next accepted pixel
    col_t                    half_w;
    col_t                    last_col;
    col_t                    tail_col;
    logic                    accept;
    logic                    col_is_tail;
    logic [KERNEL_W_MAX-1:1] mask_partial;
    logic [KERNEL_W_MAX-1:0] mask_full;
    sum_t [KERNEL_W_MAX-1:0] new_sum;       // This column's sum in each datapath
    sum_t [KERNEL_W_MAX-1:1] carry_q;       // Partial sum waiting for datapath i

    assign accept   = pixel_valid && ready;
    assign half_w   = col_t'(kw_q >> 1);
    assign last_col = cols_q - col_t'(1);
    assign tail_col = last_col - half_w;

    // Rows no wider than kw/2 have their tail already on column 0
    assign col_is_tail = col_q == tail_col || (col_q == '0 && cols_q <= half_w);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            kw_q   <= '0;
            cols_q <= '0;
            col_q  <= '0;
        end else if (start) begin
            kw_q   <= kernel_w;
            cols_q <= row_cols;
            col_q  <= '0;
        end else if (accept) begin
            col_q <= col_q == last_col ? '0 : col_q + col_t'(1);  // Next row needs no start
        end
    end

    pad_filter #(
        .KERNEL_W_MAX (KERNEL_W_MAX)
    ) u_pad_filter (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .start        (start),
        .kernel_w     (kernel_w),
        .col_valid    (accept),
        .col_is_tail  (col_is_tail),
        .mask_partial (mask_partial),
        .mask_full    (mask_full)
    );

    // Datapath 0 opens a window and the others extend the carry from below
    assign new_sum[0] = sum_t'(pixel) * sum_t'(weights[0]);
    for (genvar i = 1; i < KERNEL_W_MAX; i++) begin : g_mac
        assign new_sum[i] = sum_t'(pixel) * sum_t'(weights[i]) + carry_q[i];
    end

    always_ff @(posedge aclk) begin
        if (!rst_n || start) begin
            carry_q <= '0;                  // A fresh row sees zeros on its left
        end else if (accept) begin
            for (int i = 1; i < KERNEL_W_MAX; i++) begin
                carry_q[i] <= mask_partial[i] ? new_sum[i-1] : '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_keep  <= '0;
        end else begin
            out_valid <= accept && |mask_full;          // One cycle after the pixel
            out_keep  <= accept ? mask_full : '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) out_sums <= new_sum;
    end

endmodule

//--- rtl/conv_pad_top.sv
module conv_pad_top
    import conv_pkg::*;
#(
    parameter int KERNEL_W_MAX = 7
) (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  waddr_t                     wr_addr,
    input  weight_t                    wr_data,
    output logic                       wr_busy,
    input  logic                       start,
    input  kw_t                        kernel_w,
    input  col_t                       row_cols,
    output logic                       ready,
    input  logic                       pixel_valid,
    input  pixel_t                     pixel,
    output logic                       out_valid,
    output logic [KERNEL_W_MAX-1:0]    out_keep,
    output sum_t [KERNEL_W_MAX-1:0]    out_sums
);

    weight_t [KERNEL_W_MAX-1:0] weights;    // Fetched kernel, one word per datapath

    mem_bus_if host_bus ();
    mem_bus_if fetch_bus ();

    host_write_port u_host_port (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_busy (wr_busy),
        .bus     (host_bus.requester)
    );

    weight_fetch #(
        .KERNEL_W_MAX (KERNEL_W_MAX)
    ) u_fetch (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .start    (start),
        .kernel_w (kernel_w),
        .ready    (ready),
        .weights  (weights),
        .bus      (fetch_bus.requester)
    );

    weight_store u_store (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .host_bus  (host_bus.store),
        .fetch_bus (fetch_bus.store)
    );

    conv_row_engine #(
        .KERNEL_W_MAX (KERNEL_W_MAX)
    ) u_engine (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .start       (start),
        .kernel_w    (kernel_w),
        .row_cols    (row_cols),
        .ready       (ready),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .weights     (weights),
        .out_valid   (out_valid),
        .out_keep    (out_keep),
        .out_sums    (out_sums)
    );

endmodule

//--- bench/conv_pad_properties.sv
module conv_pad_properties #(
    parameter int KERNEL_W_MAX = 7
) (
    input logic                    aclk,
    input logic                    rst_n,
    input logic                    wr_busy,
    input logic                    ready,
    input logic                    pixel_valid,
    input logic                    out_valid,
    input logic [KERNEL_W_MAX-1:0] out_keep
);
    timeunit 1ns;
    timeprecision 1ps;

    // The first cycle out of reset still shows the values loaded by reset
    reset_values: assert property (@(posedge aclk)
        $rose(rst_n) |-> !ready && !wr_busy && !out_valid && out_keep == '0)
        else $error("Outputs were not at their reset values after reset");

    keep_matches_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid == (|out_keep))               // A valid cycle always carries a kept sum
        else $error("out_valid disagrees with out_keep");

    valid_needs_pixel: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid |-> $past(pixel_valid && ready))  // Output is one cycle behind the pixel
        else $error("out_valid rose without an accepted pixel one cycle earlier");

    busy_clears: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(wr_busy) |-> ##[1:4] !wr_busy)    // Arbiter lets the host in quickly
        else $error("wr_busy stayed high for more than four cycles");

endmodule

bind conv_pad_top conv_pad_properties #(
    .KERNEL_W_MAX (KERNEL_W_MAX)
) u_properties (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .wr_busy     (wr_busy),
    .ready       (ready),
    .pixel_valid (pixel_valid),
    .out_valid   (out_valid),
    .out_keep    (out_keep)
);

//--- bench/conv_pad_tb.sv
module conv_pad_tb
    import conv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int KW_MAX   = 7;
    localparam int WAIT_MAX = 200;          // Cycles any one wait may take

    logic                 aclk;
    logic                 rst_n;
    logic                 wr_en;
    waddr_t               wr_addr;
    weight_t              wr_data;
    logic                 wr_busy;
    logic                 start;
    kw_t                  kernel_w;
    col_t                 row_cols;
    logic                 ready;
    logic                 pixel_valid;
    pixel_t               pixel;
    logic                 out_valid;
    logic [KW_MAX-1:0]    out_keep;
    sum_t [KW_MAX-1:0]    out_sums;

    int seed = 32'h58a5;
    int wmem [0:15];                        // Model of the weight memory
    int expect_q [$];                       // Model sums in output order
    int got_q [$];                          // Kept sums taken from the DUT
    int errors = 0;
    int checks = 0;
    int cur_kw;
    int cur_cols;
    int race_data [3:6];
    int race_cols;

    conv_pad_top #(
        .KERNEL_W_MAX (KW_MAX)
    ) UUT (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_busy     (wr_busy),
        .start       (start),
        .kernel_w    (kernel_w),
        .row_cols    (row_cols),
        .ready       (ready),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .out_valid   (out_valid),
        .out_keep    (out_keep),
        .out_sums    (out_sums)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Highest datapath first within a cycle
    always @(negedge aclk) begin
        if (out_valid) begin
            for (int i = KW_MAX - 1; i >= 0; i--) begin
                if (out_keep[i]) got_q.push_back(int'($signed(out_sums[i])));
            end
        end
    end

    function automatic int rand_range(int lo, int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % (hi - lo + 1));
    endfunction

    task automatic report_and_finish();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        errors++;
        $display("Timed out while waiting for %s", what);
        report_and_finish();
    endtask

    task automatic check_value(string name, int exp, int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic wait_not_busy();
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(negedge aclk);
            if (!wr_busy) return;
        end
        give_up("wr_busy to fall");
    endtask

    task automatic wait_ready();
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(negedge aclk);
            if (ready) return;
        end
        give_up("ready after a weight fetch");
    endtask

    task automatic wait_outputs(int count);
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(posedge aclk);
            if (got_q.size() >= count) return;
        end
        give_up("the kept sums of a row");
    endtask

    task automatic host_write(int addr, int data);
        wait_not_busy();
        @(posedge aclk);
        wr_en   <= 1'b1;
        wr_addr <= waddr_t'(addr);
        wr_data <= weight_t'(data);
        @(posedge aclk);
        wr_en <= 1'b0;
        @(negedge aclk);
        check_value("write busy", 1, int'(wr_busy));   // Buffer holds the word until granted
        wmem[addr] = int'(weight_t'(data));     // Lands in memory on the grant
    endtask

    task automatic load_kernel(int kw, int cols);
        @(posedge aclk);
        start    <= 1'b1;
        kernel_w <= kw_t'(kw);
        row_cols <= col_t'(cols);
        @(posedge aclk);
        start <= 1'b0;
        cur_kw   = kw;
        cur_cols = cols;
        wait_ready();
    endtask

    task automatic drive_pixel(int value);
        @(posedge aclk);
        if (($random(seed) & 3) == 0) begin
            pixel_valid <= 1'b0;                // Idle slot inside the row
            @(posedge aclk);
        end
        pixel_valid <= 1'b1;
        pixel       <= pixel_t'(value);
    endtask

    // Rows follow each other without a new start
    task automatic run_rows(string name, int rows);
        int pix [0:1023];
        int sum;
        int half;
        half = cur_kw / 2;
        got_q.delete();
        expect_q.delete();
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cur_cols; c++) pix[c] = int'(pixel_t'($random(seed)));
            for (int c = 0; c < cur_cols; c++) begin
                sum = 0;
                for (int j = 0; j < cur_kw; j++) begin
                    if (c + j - half >= 0 && c + j - half < cur_cols)
                        sum += wmem[j] * pix[c + j - half];     // Zero padding outside
                end
                expect_q.push_back(sum);
            end
            for (int c = 0; c < cur_cols; c++) drive_pixel(pix[c]);
        end
        @(posedge aclk);
        pixel_valid <= 1'b0;
        wait_outputs(expect_q.size());
        repeat (4) @(posedge aclk);             // Nothing more may arrive
        check_value({name, " count"}, expect_q.size(), got_q.size());
        for (int k = 0; k < expect_q.size() && k < got_q.size(); k++)
            check_value($sformatf("%s sum %0d", name, k), expect_q[k], got_q[k]);
    endtask

    initial begin
        #1_000_000;
        give_up("the end of the whole run");
    end

    initial begin
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        start       = 1'b0;
        kernel_w    = kw_t'(3);
        row_cols    = col_t'(12);
        pixel_valid = 1'b0;
        pixel       = '0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;

        for (int n = 0; n < 20; n++) begin      // No kernel yet so pixels go nowhere
            @(negedge aclk);
            check_value("idle ready", 0, int'(ready));
            check_value("idle out_valid", 0, int'(out_valid));
            @(posedge aclk);
            pixel_valid <= 1'b1;
            pixel       <= pixel_t'($random(seed));
        end
        @(posedge aclk);
        pixel_valid <= 1'b0;
        repeat (2) @(posedge aclk);
        check_value("idle outputs", 0, got_q.size());

        for (int a = 0; a < 16; a++) host_write(a, $random(seed));
        for (int n = 0; n < 20; n++) host_write(rand_range(0, 15), $random(seed));
        load_kernel(7, rand_range(12, 20));
        run_rows("host weights kw7", 2);

        for (int kw = 3; kw <= 7; kw += 2) begin
            for (int a = 0; a < kw; a++) host_write(a, $random(seed));
            load_kernel(kw, rand_range(12, 20));
            run_rows($sformatf("kw%0d rows", kw), 3);
            load_kernel(kw, kw / 2 + 1);        // Narrowest legal row
            run_rows($sformatf("kw%0d narrow", kw), 2);
        end

        race_cols = rand_range(12, 20);         // Row width and words for the race
        for (int a = 3; a < 7; a++) race_data[a] = $random(seed);
        fork
            load_kernel(3, race_cols);
            begin
                for (int a = 3; a < 7; a++) host_write(a, race_data[a]);
                wait_not_busy();
            end
        join
        run_rows("fetch race kw3", 2);
        load_kernel(7, rand_range(12, 20));     // Reads back the words written in the race
        run_rows("fetch race kw7", 2);

        repeat (4) @(posedge aclk);
        report_and_finish();
    end

endmodule

//--- sources.f
rtl/conv_pkg.sv
rtl/mem_bus_if.sv
rtl/host_write_port.sv
rtl/weight_fetch.sv
rtl/weight_store.sv
rtl/pad_filter.sv
rtl/conv_row_engine.sv
rtl/conv_pad_top.sv
bench/conv_pad_properties.sv
bench/conv_pad_tb.sv

//--- Bender.yml
package:
  name: conv_pad

sources:
  - rtl/conv_pkg.sv
  - rtl/mem_bus_if.sv
  - rtl/host_write_port.sv
  - rtl/weight_fetch.sv
  - rtl/weight_store.sv
  - rtl/pad_filter.sv
  - rtl/conv_row_engine.sv
  - rtl/conv_pad_top.sv
  - target: simulation
    files:
      - bench/conv_pad_properties.sv
      - bench/conv_pad_tb.sv
